//--- badge_pkg.sv
package badge_pkg;

    // ------------------------------------------------------------------------
    // Bus geometry
    // ------------------------------------------------------------------------
    localparam int BUS_DATA_W = 32;
    localparam int BUS_SEL_W  = 4;
    localparam int BUS_ADDR_W = 32;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam int REGION_HI = 31;
    localparam int REGION_LO = 28;
    localparam logic [REGION_HI-REGION_LO:0] PERIPH_REGION = 4'h4;

    localparam int SUB_HI = 19;
    localparam int SUB_LO = 16;
    localparam logic [SUB_HI-SUB_LO:0] MISC_SUB = 4'h0;

    // Word offset inside the misc block
    localparam int REG_OFF_HI = 4;
    localparam int REG_OFF_LO = 2;
    localparam int REG_OFF_W  = REG_OFF_HI - REG_OFF_LO + 1;

    localparam logic [REG_OFF_W-1:0] REG_LED        = 3'd0;
    localparam logic [REG_OFF_W-1:0] REG_BUTTONS    = 3'd1;
    localparam logic [REG_OFF_W-1:0] REG_IRQ_STATUS = 3'd2;
    localparam logic [REG_OFF_W-1:0] REG_IRQ_ENABLE = 3'd3;
    localparam logic [REG_OFF_W-1:0] REG_AUDIO      = 3'd4;

    // ------------------------------------------------------------------------
    // Audio path
    // ------------------------------------------------------------------------
    localparam int SAMPLE_W    = 8;
    localparam int MIC_CLK_DIV = 32;
    localparam int DECIM_LEN   = 64;
    localparam int FIFO_DEPTH  = 8;

    localparam int MIC_DIV_W   = $clog2(MIC_CLK_DIV);
    localparam int DECIM_CNT_W = $clog2(DECIM_LEN);
    // Ones count runs 0 to DECIM_LEN inclusive
    localparam int ONES_W      = $clog2(DECIM_LEN + 1);
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);

    // Audio register fields above the sample byte
    localparam int AUDIO_VALID_BIT = SAMPLE_W;
    localparam int AUDIO_OVF_BIT   = SAMPLE_W + 1;

    localparam int NUM_BUTTONS = 2;
    localparam int NUM_LEDS    = 3;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] wdata;
        logic [BUS_SEL_W-1:0]  sel;
    } bus_req_t;

    typedef struct packed {
        logic                  ack;
        logic                  err;
        logic [BUS_DATA_W-1:0] rdata;
    } bus_rsp_t;

    // Bit order matches REG_LED, r in bit 0
    typedef struct packed {
        logic b;
        logic g;
        logic r;
    } led_t;

    // up in bit 1, down in bit 0
    typedef struct packed {
        logic up;
        logic down;
    } buttons_t;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

//--- pdm_mic_decimator.sv
`timescale 1ns/10ps

module pdm_mic_decimator
    import badge_pkg::*;
(
    input  logic    clk_96mhz,
    input  logic    rst_n_i,
    input  logic    mic_data_i,
    output logic    mic_clk_o,
    output logic    sample_valid_o,
    output sample_t sample_o
);

    logic [MIC_DIV_W-1:0]   div_cnt;
    logic                   mic_clk_q;
    logic                   bit_stb;
    logic [DECIM_CNT_W-1:0] bit_cnt;
    logic [ONES_W-1:0]      ones_acc;
    logic [ONES_W-1:0]      ones_total;
    logic                   window_end;
    logic                   valid_q;
    sample_t                sample_q;

    // ------------------------------------------------------------------------
    // Microphone clock
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_96mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt   <= '0;
            mic_clk_q <= 1'b0;
        end else begin
            if (div_cnt == MIC_DIV_W'(MIC_CLK_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            mic_clk_q <= (div_cnt < MIC_DIV_W'(MIC_CLK_DIV / 2));
        end
    end

    assign mic_clk_o = mic_clk_q;

    // Clock flop trails the counter by one, so count 1 is the rising cycle
    assign bit_stb = (div_cnt == MIC_DIV_W'(1));

    // ------------------------------------------------------------------------
    // Window accumulation
    // ------------------------------------------------------------------------
    assign ones_total = ones_acc + ONES_W'(mic_data_i);
    assign window_end = bit_stb && (bit_cnt == DECIM_CNT_W'(DECIM_LEN - 1));

    always_ff @(posedge clk_96mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt  <= '0;
            ones_acc <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= window_end;
            if (window_end) begin
                bit_cnt  <= '0;
                ones_acc <= '0;
            end else if (bit_stb) begin
                bit_cnt  <= bit_cnt + 1'b1;
                ones_acc <= ones_total;
            end
        end
    end

    // Remove the DC offset of half a window
    always_ff @(posedge clk_96mhz) begin
        if (window_end) begin
            sample_q <= sample_t'(SAMPLE_W'(ones_total) - SAMPLE_W'(DECIM_LEN / 2));
        end
    end

    assign sample_valid_o = valid_q;
    assign sample_o       = sample_q;

endmodule

//--- sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo
    import badge_pkg::*;
(
    input  logic    clk_96mhz,
    input  logic    rst_n_i,
    input  logic    push_i,
    input  sample_t push_data_i,
    input  logic    pop_i,
    input  logic    clr_overflow_i,
    output sample_t head_o,
    output logic    empty_o,
    output logic    overflow_o
);

    sample_t                mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_CNT_W-1:0]  count;
    logic                   full;
    logic                   pop_ok;
    logic                   push_ok;
    logic                   overflow_q;

    assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign pop_ok  = pop_i && !empty_o;
    // A pop on the same edge frees the slot a full FIFO needs
    assign push_ok = push_i && (!full || pop_ok);

    always_ff @(posedge clk_96mhz) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_96mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // New loss wins over a clear on the same edge
            if (push_i && !push_ok) begin
                overflow_q <= 1'b1;
            end else if (clr_overflow_i) begin
                overflow_q <= 1'b0;
            end
        end
    end

    assign head_o     = mem[rd_ptr];
    assign overflow_o = overflow_q;

endmodule

//--- misc_regs.sv
`timescale 1ns/10ps

module misc_regs
    import badge_pkg::*;
(
    input  logic     clk_96mhz,
    input  logic     rst_n_i,
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,
    input  buttons_t buttons_i,
    output led_t     leds_o,
    output logic     irq_o,
    input  sample_t  fifo_head_i,
    input  logic     fifo_empty_i,
    input  logic     fifo_overflow_i,
    output logic     fifo_pop_o,
    output logic     fifo_clr_overflow_o
);

    logic                   req_live;
    logic                   mapped;
    logic [REG_OFF_W-1:0]   reg_off;
    logic                   wr_en;
    logic                   rd_audio;
    logic [BUS_DATA_W-1:0]  rd_word;
    logic [NUM_BUTTONS-1:0] w1c;
    logic [NUM_BUTTONS-1:0] press;
    buttons_t               btn_meta;
    buttons_t               btn_sync;
    buttons_t               btn_prev;
    logic [NUM_BUTTONS-1:0] irq_status_q;
    logic [NUM_BUTTONS-1:0] irq_enable_q;
    led_t                   led_q;
    logic                   ack_q;
    logic                   err_q;
    logic                   pop_q;
    logic                   clr_ovf_q;
    logic                   irq_q;
    logic [BUS_DATA_W-1:0]  rdata_q;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    // Held request is masked while our own response is out
    assign req_live = bus_req_i.cyc && bus_req_i.stb && !(ack_q || err_q);
    assign mapped   = (bus_req_i.addr[REGION_HI:REGION_LO] == PERIPH_REGION) &&
                      (bus_req_i.addr[SUB_HI:SUB_LO] == MISC_SUB);
    assign reg_off  = bus_req_i.addr[REG_OFF_HI:REG_OFF_LO];
    assign wr_en    = req_live && mapped && bus_req_i.we && bus_req_i.sel[0];
    assign rd_audio = req_live && mapped && !bus_req_i.we && (reg_off == REG_AUDIO);

    assign w1c = (wr_en && reg_off == REG_IRQ_STATUS) ?
                 bus_req_i.wdata[NUM_BUTTONS-1:0] : '0;

    always_comb begin
        rd_word = '0;
        case (reg_off)
            REG_LED:        rd_word[NUM_LEDS-1:0]    = led_q;
            REG_BUTTONS:    rd_word[NUM_BUTTONS-1:0] = btn_sync;
            REG_IRQ_STATUS: rd_word[NUM_BUTTONS-1:0] = irq_status_q;
            REG_IRQ_ENABLE: rd_word[NUM_BUTTONS-1:0] = irq_enable_q;
            REG_AUDIO: begin
                rd_word[SAMPLE_W-1:0]   = fifo_empty_i ? '0 : fifo_head_i;
                rd_word[AUDIO_VALID_BIT] = !fifo_empty_i;
                rd_word[AUDIO_OVF_BIT]   = fifo_overflow_i;
            end
            default:        rd_word = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Bus response, one cycle after the request
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_96mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            pop_q     <= 1'b0;
            clr_ovf_q <= 1'b0;
        end else begin
            ack_q     <= req_live && mapped;
            err_q     <= req_live && !mapped;
            // FIFO pops at the end of the ack cycle
            pop_q     <= rd_audio && !fifo_empty_i;
            clr_ovf_q <= rd_audio;
        end
    end

    always_ff @(posedge clk_96mhz) begin
        if (req_live) begin
            rdata_q <= (mapped && !bus_req_i.we) ? rd_word : '0;
        end
    end

    assign bus_rsp_o = '{ack: ack_q, err: err_q, rdata: rdata_q};

    // ------------------------------------------------------------------------
    // Registers, buttons and interrupt
    // ------------------------------------------------------------------------
    assign press = btn_sync & ~btn_prev;

    always_ff @(posedge clk_96mhz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            btn_meta     <= '0;
            btn_sync     <= '0;
            btn_prev     <= '0;
            led_q        <= '0;
            irq_status_q <= '0;
            irq_enable_q <= '0;
            irq_q        <= 1'b0;
        end else begin
            btn_meta <= buttons_i;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            if (wr_en && reg_off == REG_LED) begin
                led_q <= led_t'(bus_req_i.wdata[NUM_LEDS-1:0]);
            end
            if (wr_en && reg_off == REG_IRQ_ENABLE) begin
                irq_enable_q <= bus_req_i.wdata[NUM_BUTTONS-1:0];
            end
            // Fresh press beats a clear on the same edge
            irq_status_q <= (irq_status_q & ~w1c) | press;
            irq_q        <= |(irq_status_q & irq_enable_q);
        end
    end

    assign leds_o              = led_q;
    assign irq_o               = irq_q;
    assign fifo_pop_o          = pop_q;
    assign fifo_clr_overflow_o = clr_ovf_q;

endmodule

//--- periph_top.sv
`timescale 1ns/10ps

module periph_top
    import badge_pkg::*;
(
    input  logic     clk_96mhz,
    input  logic     rst_n_i,
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,
    input  buttons_t buttons_i,
    input  logic     mic_data_i,
    output logic     mic_clk_o,
    output led_t     leds_o,
    output logic     irq_o
);

    // Producer to buffer
    logic    sample_valid;
    sample_t sample;

    // Buffer to register block
    sample_t fifo_head;
    logic    fifo_empty;
    logic    fifo_overflow;
    logic    fifo_pop;
    logic    fifo_clr_overflow;

    pdm_mic_decimator mic_i (
        .clk_96mhz      (clk_96mhz),
        .rst_n_i        (rst_n_i),
        .mic_data_i     (mic_data_i),
        .mic_clk_o      (mic_clk_o),
        .sample_valid_o (sample_valid),
        .sample_o       (sample)
    );

    sample_fifo fifo_i (
        .clk_96mhz      (clk_96mhz),
        .rst_n_i        (rst_n_i),
        .push_i         (sample_valid),
        .push_data_i    (sample),
        .pop_i          (fifo_pop),
        .clr_overflow_i (fifo_clr_overflow),
        .head_o         (fifo_head),
        .empty_o        (fifo_empty),
        .overflow_o     (fifo_overflow)
    );

    misc_regs regs_i (
        .clk_96mhz           (clk_96mhz),
        .rst_n_i             (rst_n_i),
        .bus_req_i           (bus_req_i),
        .bus_rsp_o           (bus_rsp_o),
        .buttons_i           (buttons_i),
        .leds_o              (leds_o),
        .irq_o               (irq_o),
        .fifo_head_i         (fifo_head),
        .fifo_empty_i        (fifo_empty),
        .fifo_overflow_i     (fifo_overflow),
        .fifo_pop_o          (fifo_pop),
        .fifo_clr_overflow_o (fifo_clr_overflow)
    );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

//--- tb_periph_top.sv
`timescale 1ns/10ps

module tb_periph_top
    import badge_pkg::*;
();

    localparam int CLK_PERIOD_NS = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 16;
    localparam int WINDOW_CYCLES = DECIM_LEN * MIC_CLK_DIV;
    localparam int BUS_TIMEOUT   = 16;
    localparam int POLL_GAP      = 8;
    localparam int WATCHDOG_NS   = 40 * WINDOW_CYCLES * CLK_PERIOD_NS;

    typedef struct packed {
        sample_t got;
        sample_t exp;
    } sample_pair_t;

    logic         clk_96mhz;
    logic         rst_n;
    bus_req_t     bus_req;
    bus_rsp_t     bus_rsp;
    buttons_t     buttons;
    logic         mic_data;
    logic         mic_clk;
    led_t         leds;
    logic         irq;

    integer       seed;
    int           check_pass;
    int           check_fail;
    int           test_mark;
    logic [3:0]   mic_pattern;
    logic [1:0]   mic_bit_idx;
    logic         mic_clk_prev;
    sample_pair_t pair_q[$];
    event         sample_queued;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen_i (.clk_o(clk_96mhz));

    periph_top dut_i (
        .clk_96mhz  (clk_96mhz),
        .rst_n_i    (rst_n),
        .bus_req_i  (bus_req),
        .bus_rsp_o  (bus_rsp),
        .buttons_i  (buttons),
        .mic_data_i (mic_data),
        .mic_clk_o  (mic_clk),
        .leds_o     (leds),
        .irq_o      (irq)
    );

    // --------------------------------------------------------------------------
    // Reference model and compare tasks
    // --------------------------------------------------------------------------
    function automatic logic [BUS_ADDR_W-1:0] reg_addr(input logic [REG_OFF_W-1:0] off);
        return {PERIPH_REGION, 8'h00, MISC_SUB, 11'h000, off, 2'b00};
    endfunction

    // Period-four pattern divides the window, so alignment does not matter
    function automatic sample_t expected_sample(input logic [3:0] pattern);
        int ones;
        ones = 0;
        for (int i = 0; i < 4; i++) begin
            ones += pattern[i];
        end
        return sample_t'(ones * (DECIM_LEN / 4) - DECIM_LEN / 2);
    endfunction

    task automatic check_word(input string name, input bus_rsp_t rsp,
                              input logic [BUS_DATA_W-1:0] exp);
        if (!rsp.ack) begin
            $display("%s: the read was not acknowledged", name);
            check_fail++;
        end else if (rsp.rdata !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, rsp.rdata, exp);
            check_fail++;
        end else begin
            check_pass++;
        end
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%02h expected 0x%02h", name, got, exp);
            check_fail++;
        end else begin
            check_pass++;
        end
    endtask

    task automatic check_leds(input string name, input led_t got, input led_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%01h expected 0x%01h", name, got, exp);
            check_fail++;
        end else begin
            check_pass++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got 0x%01h expected 0x%01h", name, got, exp);
            check_fail++;
        end else begin
            check_pass++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            check_fail++;
        end else begin
            check_pass++;
        end
    endtask

    // Audio samples are checked by their own process as they are queued
    initial begin
        forever begin
            @(sample_queued);
            while (pair_q.size() != 0) begin
                check_sample("audio sample", pair_q[0].got, pair_q[0].exp);
                pair_q.delete(0);
            end
        end
    end

    task automatic queue_sample(input sample_t got, input sample_t exp);
        sample_pair_t pair;
        pair.got = got;
        pair.exp = exp;
        pair_q.push_back(pair);
        -> sample_queued;
    endtask

    // --------------------------------------------------------------------------
    // Sequencing and bus tasks
    // --------------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_96mhz);
        #DRIVE_DELAY;
    endtask

    task automatic start_test();
        test_mark = check_fail;
    endtask

    task automatic end_test(input string name);
        int errors;
        wait_cycles(1);
        errors = check_fail - test_mark;
        if (errors == 0) begin
            $display("test %-18s ok", name);
        end else begin
            $display("test %-18s %0d error(s)", name, errors);
        end
    endtask

    // One whole high phase of the mic clock and the low phase after it
    task automatic measure_mic_clk(output int high_cycles, output int low_cycles);
        int guard;
        high_cycles = 0;
        low_cycles = 0;
        guard = 0;
        while (mic_clk !== 1'b0 && guard < MIC_CLK_DIV) begin
            wait_cycles(1);
            guard++;
        end
        while (mic_clk !== 1'b1 && guard < 2 * MIC_CLK_DIV) begin
            wait_cycles(1);
            guard++;
        end
        while (mic_clk === 1'b1 && high_cycles < MIC_CLK_DIV) begin
            wait_cycles(1);
            high_cycles++;
        end
        while (mic_clk === 1'b0 && low_cycles < MIC_CLK_DIV) begin
            wait_cycles(1);
            low_cycles++;
        end
    endtask

    // Holds the request until ack or err, then drops it in the response cycle
    task automatic bus_access(input logic we, input logic [BUS_ADDR_W-1:0] addr,
                              input logic [BUS_DATA_W-1:0] data,
                              input logic [BUS_SEL_W-1:0] sel, output bus_rsp_t rsp);
        int waited;
        waited = 0;
        rsp = '0;
        bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, wdata: data, sel: sel};
        do begin
            wait_cycles(1);
            waited++;
        end while (!(bus_rsp.ack || bus_rsp.err) && waited < BUS_TIMEOUT);
        if (bus_rsp.ack || bus_rsp.err) begin
            rsp = bus_rsp;
        end else begin
            $display("bus request to 0x%08h got no response", addr);
            check_fail++;
        end
        bus_req = '0;
    endtask

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr,
                             input logic [BUS_DATA_W-1:0] data,
                             input logic [BUS_SEL_W-1:0] sel);
        bus_rsp_t rsp;
        bus_access(1'b1, addr, data, sel, rsp);
        check_flag("write ack", rsp.ack, 1'b1);
    endtask

    task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output bus_rsp_t rsp);
        bus_access(1'b0, addr, '0, '1, rsp);
    endtask

    task automatic drain_fifo();
        bus_rsp_t rsp;
        int reads;
        reads = 0;
        do begin
            bus_read(reg_addr(REG_AUDIO), rsp);
            reads++;
        end while (rsp.rdata[AUDIO_VALID_BIT] && reads < FIFO_DEPTH + 4);
        if (rsp.rdata[AUDIO_VALID_BIT]) begin
            $display("the sample FIFO did not drain after %0d reads", reads);
            check_fail++;
        end
    endtask

    // Returns right after a freshly decimated sample has been read
    task automatic wait_fresh_sample(output sample_t s, output logic found);
        bus_rsp_t rsp;
        int polls;
        polls = 0;
        found = 1'b0;
        s = '0;
        while (!found && polls < 2 * WINDOW_CYCLES / POLL_GAP) begin
            bus_read(reg_addr(REG_AUDIO), rsp);
            polls++;
            if (rsp.rdata[AUDIO_VALID_BIT]) begin
                found = 1'b1;
                s = sample_t'(rsp.rdata[SAMPLE_W-1:0]);
            end else begin
                wait_cycles(POLL_GAP);
            end
        end
        if (!found) begin
            $display("no audio sample arrived within two windows");
            check_fail++;
        end
    endtask

    // Mixed windows are flushed before the first clean sample is taken
    task automatic measure_pattern(input logic [3:0] pattern);
        sample_t s;
        logic found;
        mic_pattern = pattern;
        wait_cycles(2 * WINDOW_CYCLES);
        drain_fifo();
        wait_fresh_sample(s, found);
        if (found) begin
            queue_sample(s, expected_sample(pattern));
        end
    endtask

    // PDM source, next pattern bit on each mic clock rise
    initial begin
        mic_bit_idx = '0;
        mic_clk_prev = 1'b0;
        forever begin
            @(posedge clk_96mhz);
            #DRIVE_DELAY;
            if (mic_clk && !mic_clk_prev) begin
                mic_data = mic_pattern[mic_bit_idx];
                mic_bit_idx = mic_bit_idx + 1'b1;
            end
            mic_clk_prev = mic_clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // --------------------------------------------------------------------------
    // Tests
    // --------------------------------------------------------------------------
    initial begin
        bus_rsp_t rsp;
        logic [BUS_ADDR_W-1:0] bad_addr;
        logic [2:0] led_val;
        led_t exp_leds;
        sample_t s;
        logic found;
        int valid_reads;
        int high_cycles;
        int low_cycles;

        seed = 32'h1c27a0a7;
        check_pass = 0;
        check_fail = 0;
        test_mark = 0;
        rst_n = 1'b0;
        bus_req = '0;
        buttons = '0;
        mic_data = 1'b0;
        mic_pattern = 4'h0;
        led_val = '0;
        exp_leds = '0;

        start_test();
        repeat (RESET_CYCLES) @(posedge clk_96mhz);
        #DRIVE_DELAY;
        check_flag("mic_clk_o in reset", mic_clk, 1'b0);
        check_leds("leds_o in reset", leds, '0);
        check_flag("irq_o in reset", irq, 1'b0);
        rst_n = 1'b1;
        wait_cycles(2);
        measure_mic_clk(high_cycles, low_cycles);
        check_count("mic_clk_o high cycles", high_cycles, MIC_CLK_DIV / 2);
        check_count("mic_clk_o low cycles", low_cycles, MIC_CLK_DIV / 2);
        end_test("reset and mic clock");

        start_test();
        for (int i = 0; i < 4; i++) begin
            led_val = 3'($random(seed));
            exp_leds = '{r: led_val[0], g: led_val[1], b: led_val[2]};
            bus_write(reg_addr(REG_LED), {29'h0, led_val}, 4'hf);
            bus_read(reg_addr(REG_LED), rsp);
            check_word("led rdata", rsp, {29'h0, led_val});
            check_leds("leds_o", leds, exp_leds);
        end
        // Byte lane 0 disabled
        bus_write(reg_addr(REG_LED), {29'h0, ~led_val}, 4'he);
        bus_read(reg_addr(REG_LED), rsp);
        check_word("led rdata after sel0 clear", rsp, {29'h0, led_val});
        check_leds("leds_o", leds, exp_leds);
        end_test("led register");

        start_test();
        bad_addr = reg_addr(REG_LED);
        bad_addr[REGION_HI:REGION_LO] = 4'h5;
        bus_access(1'b1, bad_addr, {29'h0, ~led_val}, 4'hf, rsp);
        check_flag("err for wrong region", rsp.err, 1'b1);
        check_flag("ack for wrong region", rsp.ack, 1'b0);
        bad_addr = reg_addr(REG_LED);
        bad_addr[SUB_HI:SUB_LO] = 4'h3;
        bus_access(1'b1, bad_addr, {29'h0, ~led_val}, 4'hf, rsp);
        check_flag("err for wrong sub", rsp.err, 1'b1);
        check_flag("ack for wrong sub", rsp.ack, 1'b0);
        bus_read(reg_addr(REG_LED), rsp);
        check_word("led rdata after unmapped writes", rsp, {29'h0, led_val});
        bus_read(reg_addr(3'd5), rsp);
        check_word("unused offset rdata", rsp, 32'h0);
        end_test("address decode");

        start_test();
        buttons.up = 1'b1;
        wait_cycles(6);
        bus_read(reg_addr(REG_BUTTONS), rsp);
        check_word("buttons rdata", rsp, 32'h2);
        bus_read(reg_addr(REG_IRQ_STATUS), rsp);
        check_word("irq status after press", rsp, 32'h2);
        check_flag("irq_o while disabled", irq, 1'b0);
        bus_write(reg_addr(REG_IRQ_ENABLE), 32'h2, 4'hf);
        wait_cycles(2);
        check_flag("irq_o when enabled", irq, 1'b1);
        bus_write(reg_addr(REG_IRQ_STATUS), 32'h2, 4'hf);
        wait_cycles(2);
        check_flag("irq_o after clear", irq, 1'b0);
        bus_read(reg_addr(REG_IRQ_STATUS), rsp);
        check_word("irq status after clear", rsp, 32'h0);
        // Button still held, so no new edge
        wait_cycles(20);
        bus_read(reg_addr(REG_IRQ_STATUS), rsp);
        check_word("irq status while held", rsp, 32'h0);
        check_flag("irq_o while held", irq, 1'b0);
        buttons.up = 1'b0;
        bus_write(reg_addr(REG_IRQ_ENABLE), 32'h0, 4'hf);
        end_test("button interrupt");

        start_test();
        for (int i = 0; i < 3; i++) begin
            measure_pattern(4'($random(seed)));
        end
        end_test("audio random");

        start_test();
        measure_pattern(4'hf);
        measure_pattern(4'h0);
        end_test("audio full scale");

        // Next sample is a whole window away
        start_test();
        bus_read(reg_addr(REG_AUDIO), rsp);
        check_flag("audio valid on empty FIFO", rsp.rdata[AUDIO_VALID_BIT], 1'b0);
        end_test("audio empty");

        start_test();
        drain_fifo();
        wait_fresh_sample(s, found);
        if (found) begin
            queue_sample(s, expected_sample(4'h0));
        end
        wait_cycles((FIFO_DEPTH + 2) * WINDOW_CYCLES + WINDOW_CYCLES / 2);
        valid_reads = 0;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            bus_read(reg_addr(REG_AUDIO), rsp);
            if (i == 0) begin
                check_flag("overflow on first read", rsp.rdata[AUDIO_OVF_BIT], 1'b1);
            end else begin
                check_flag("overflow on later read", rsp.rdata[AUDIO_OVF_BIT], 1'b0);
            end
            if (rsp.rdata[AUDIO_VALID_BIT]) begin
                valid_reads++;
                queue_sample(sample_t'(rsp.rdata[SAMPLE_W-1:0]), expected_sample(4'h0));
            end
        end
        check_count("valid reads after overflow", valid_reads, FIFO_DEPTH);
        end_test("overflow");

        $display("checks passed: %0d, failed: %0d", check_pass, check_fail);
        if (check_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
badge_pkg.sv
pdm_mic_decimator.sv
sample_fifo.sv
misc_regs.sv
periph_top.sv
tb_clk_gen.sv
tb_periph_top.sv

//--- Bender.yml
package:
  name: badge_periph

sources:
  - badge_pkg.sv
  - pdm_mic_decimator.sv
  - sample_fifo.sv
  - misc_regs.sv
  - periph_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_periph_top.sv
